// ==== list.f ====
+incdir+src
src/dacPkg.sv
src/clearSequencer.sv
src/rampGenerator.sv
src/spiArbiter.sv
src/spiFrameSender.sv
src/dacFrameReceiver.sv
src/dacSubsystem.sv
sim/tbDacSubsystem.sv

// ==== sim/tbDacSubsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dac_consts.svh"

module tbDacSubsystem;

   // Cycle limit for every wait loop
   localparam int WaitLimit = 1000;

   logic        DAC_CS;
   logic        arstN;
   logic        hostWr;
   logic [3:0]  hostCmd;
   logic [3:0]  hostAddr;
   logic [11:0] hostData;
   logic        hostBusy;
   logic        rampEn;
   logic [3:0]  rampAddr;
   logic        errClr;
   logic        dacReady;
   logic [11:0] chanA;
   logic [11:0] chanB;
   logic [11:0] chanC;
   logic [11:0] chanD;
   logic        cmdErr;
   logic        addrErr;

   // Shadow model of the DAC registers and flags
   logic [11:0] inModel [4];
   logic [11:0] outModel [4];
   logic        expCmdErr;
   logic        expAddrErr;
   int          valueErrs;
   int          otherErrs;

   dacSubsystem u_dacSubsystem (
      .DAC_CS   (DAC_CS),
      .arstN    (arstN),
      .hostWr   (hostWr),
      .hostCmd  (hostCmd),
      .hostAddr (hostAddr),
      .hostData (hostData),
      .hostBusy (hostBusy),
      .rampEn   (rampEn),
      .rampAddr (rampAddr),
      .errClr   (errClr),
      .dacReady (dacReady),
      .chanA    (chanA),
      .chanB    (chanB),
      .chanC    (chanC),
      .chanD    (chanD),
      .cmdErr   (cmdErr),
      .addrErr  (addrErr)
   );

   initial begin
      DAC_CS = 1'b0;
      forever #10 DAC_CS = ~DAC_CS;
   end

   function automatic logic [11:0] chanOut(input int idx);
      case (idx)
         0:       return chanA;
         1:       return chanB;
         2:       return chanC;
         default: return chanD;
      endcase
   endfunction

   task automatic checkChan(input string name, input logic [11:0] got, input logic [11:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
         valueErrs++;
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
         valueErrs++;
      end
   endtask

   // Compare all outputs against the shadow model
   task automatic compareAll();
      checkChan("chanA", chanA, outModel[0]);
      checkChan("chanB", chanB, outModel[1]);
      checkChan("chanC", chanC, outModel[2]);
      checkChan("chanD", chanD, outModel[3]);
      checkFlag("cmdErr", cmdErr, expCmdErr);
      checkFlag("addrErr", addrErr, expAddrErr);
   endtask

   // Expected effect of one frame on the DAC
   task automatic modelFrame(input logic [3:0] cmd, input logic [3:0] addr,
                             input logic [11:0] data);
      logic wr;
      logic upd;
      wr  = (cmd == `CMD_WRITE) || (cmd == `CMD_WRITE_UPDATE);
      upd = (cmd == `CMD_UPDATE) || (cmd == `CMD_WRITE_UPDATE);
      if (!wr && !upd) begin
         expCmdErr = 1'b1;
      end
      if (addr > 4'd3 && addr != `ADDR_ALL) begin
         expAddrErr = 1'b1;
      end
      // Flagged frames leave the registers alone
      if ((wr || upd) && (addr <= 4'd3 || addr == `ADDR_ALL)) begin
         for (int i = 0; i < 4; i++) begin
            if (addr == `ADDR_ALL || addr == 4'(i)) begin
               if (wr) inModel[i] = data;
               if (upd) outModel[i] = inModel[i];
            end
         end
      end
   endtask

   // One-cycle host strobe with an immediate busy check
   task automatic issueHost(input logic [3:0] cmd, input logic [3:0] addr,
                            input logic [11:0] data);
      @(posedge DAC_CS);
      hostWr   <= 1'b1;
      hostCmd  <= cmd;
      hostAddr <= addr;
      hostData <= data;
      @(posedge DAC_CS);
      hostWr <= 1'b0;
      @(negedge DAC_CS);
      checkFlag("hostBusy", hostBusy, 1'b1);
   endtask

   task automatic waitHostIdle();
      int t;
      t = 0;
      while (hostBusy && t < WaitLimit) begin
         @(negedge DAC_CS);
         t++;
      end
      if (hostBusy) begin
         $display("Timeout waiting for hostBusy to drop");
         otherErrs++;
      end
   endtask

   task automatic waitChanValue(input int idx, input logic [11:0] exp);
      int t;
      t = 0;
      while (chanOut(idx) !== exp && t < WaitLimit) begin
         @(negedge DAC_CS);
         t++;
      end
      if (chanOut(idx) !== exp) begin
         $display("Timeout waiting for channel %0d to change", idx);
         otherErrs++;
      end
   endtask

   // Full host transaction with model update and compare
   task automatic writeFrame(input logic [3:0] cmd, input logic [3:0] addr,
                             input logic [11:0] data);
      issueHost(cmd, addr, data);
      waitHostIdle();
      // Receiver applies the frame right after select rises
      repeat (2) @(negedge DAC_CS);
      modelFrame(cmd, addr, data);
      compareAll();
   endtask

   task automatic testResetClear();
      repeat (5) @(posedge DAC_CS);
      arstN <= 1'b1;
      @(negedge DAC_CS);
      checkFlag("dacReady", dacReady, 1'b0);
      checkFlag("hostBusy", hostBusy, 1'b0);
      compareAll();
      // Ready exactly DAC_CLR_CYCLES edges after release
      for (int i = 1; i <= `DAC_CLR_CYCLES; i++) begin
         @(posedge DAC_CS);
         @(negedge DAC_CS);
         checkFlag("dacReady", dacReady, i == `DAC_CLR_CYCLES);
      end
   endtask

   task automatic testWriteUpdate();
      logic [11:0] v;
      for (int a = 0; a < 4; a++) begin
         v = 12'($urandom);
         issueHost(`CMD_WRITE_UPDATE, 4'(a), v);
         waitChanValue(a, v);
         waitHostIdle();
         modelFrame(`CMD_WRITE_UPDATE, 4'(a), v);
         compareAll();
      end
   endtask

   task automatic testWriteThenUpdate();
      logic [11:0] v;
      v = 12'($urandom);
      // Output must hold until the update
      writeFrame(`CMD_WRITE, 4'd1, v);
      writeFrame(`CMD_UPDATE, 4'd1, 12'h000);
      for (int a = 0; a < 4; a++) begin
         writeFrame(`CMD_WRITE, 4'(a), 12'($urandom));
      end
      // Broadcast update of all four
      writeFrame(`CMD_UPDATE, `ADDR_ALL, 12'h000);
   endtask

   task automatic testIllegal();
      writeFrame(4'b0100, 4'd0, 12'($urandom));
      writeFrame(`CMD_WRITE_UPDATE, 4'b0101, 12'($urandom));
      @(posedge DAC_CS);
      errClr <= 1'b1;
      @(posedge DAC_CS);
      errClr <= 1'b0;
      @(negedge DAC_CS);
      expCmdErr  = 1'b0;
      expAddrErr = 1'b0;
      compareAll();
   endtask

   task automatic testSharedBus();
      logic [11:0] hostVal;
      logic [11:0] prevC;
      logic [11:0] expRamp;
      int          steps;
      int          t;
      // Park channel C at zero so the first ramp step shows
      writeFrame(`CMD_WRITE_UPDATE, 4'd2, 12'h000);
      hostVal = 12'($urandom);
      prevC   = chanC;
      expRamp = 12'h000;
      steps   = 0;
      @(posedge DAC_CS);
      rampAddr <= 4'd2;
      rampEn   <= 1'b1;
      // Host strobe lands near the first ramp request
      repeat (`RAMP_PERIOD - 1) @(posedge DAC_CS);
      issueHost(`CMD_WRITE_UPDATE, 4'd0, hostVal);
      t = 0;
      while ((steps < 3 || chanA !== hostVal) && t < 4 * `RAMP_PERIOD + WaitLimit) begin
         @(negedge DAC_CS);
         if (chanC !== prevC) begin
            expRamp = expRamp + `RAMP_STEP;
            checkChan("chanC", chanC, expRamp);
            prevC = chanC;
            steps++;
         end
         t++;
      end
      if (steps < 3 || chanA !== hostVal) begin
         $display("Timeout waiting for ramp steps and host write on the shared bus");
         otherErrs++;
      end
      @(posedge DAC_CS);
      rampEn <= 1'b0;
      waitHostIdle();
      inModel[2]  = expRamp;
      outModel[2] = expRamp;
      modelFrame(`CMD_WRITE_UPDATE, 4'd0, hostVal);
      @(negedge DAC_CS);
      compareAll();
   endtask

   initial begin
      void'($urandom(57566));
      arstN      = 1'b0;
      hostWr     = 1'b0;
      hostCmd    = 4'h0;
      hostAddr   = 4'h0;
      hostData   = 12'h000;
      rampEn     = 1'b0;
      rampAddr   = 4'h0;
      errClr     = 1'b0;
      valueErrs  = 0;
      otherErrs  = 0;
      expCmdErr  = 1'b0;
      expAddrErr = 1'b0;
      for (int i = 0; i < 4; i++) begin
         inModel[i]  = 12'h000;
         outModel[i] = 12'h000;
      end
      testResetClear();
      testWriteUpdate();
      testWriteThenUpdate();
      testIllegal();
      testSharedBus();
      $display("Error count: %0d value, %0d other", valueErrs, otherErrs);
      if (valueErrs == 0 && otherErrs == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/dacSubsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

module dacSubsystem import dacPkg::*; (
   input  wire         DAC_CS,
   input  wire         arstN,
   input  wire         hostWr,
   input  wire  [3:0]  hostCmd,
   input  wire  [3:0]  hostAddr,
   input  wire  [11:0] hostData,
   output logic        hostBusy,
   input  wire         rampEn,
   input  wire  [3:0]  rampAddr,
   input  wire         errClr,
   output logic        dacReady,
   output logic [11:0] chanA,
   output logic [11:0] chanB,
   output logic [11:0] chanC,
   output logic [11:0] chanD,
   output logic        cmdErr,
   output logic        addrErr
);

   logic      dacClr;
   logic      rampReq;
   logic      rampGnt;
   dacFrame_u rampFrame;
   logic      sendBusy;
   logic      sendStart;
   dacFrame_u sendFrame;
   // Serial bus between sender and DAC model
   logic      spiSck;
   logic      spiCsN;
   logic      spiMosi;

   clearSequencer u_clearSequencer (
      .DAC_CS   (DAC_CS),
      .arstN    (arstN),
      .dacClr   (dacClr),
      .dacReady (dacReady)
   );

   rampGenerator u_rampGenerator (
      .DAC_CS    (DAC_CS),
      .arstN     (arstN),
      .rampEn    (rampEn),
      .rampAddr  (rampAddr),
      .rampGnt   (rampGnt),
      .rampReq   (rampReq),
      .rampFrame (rampFrame)
   );

   spiArbiter u_spiArbiter (
      .DAC_CS    (DAC_CS),
      .arstN     (arstN),
      .dacReady  (dacReady),
      .hostWr    (hostWr),
      .hostCmd   (hostCmd),
      .hostAddr  (hostAddr),
      .hostData  (hostData),
      .hostBusy  (hostBusy),
      .rampReq   (rampReq),
      .rampFrame (rampFrame),
      .rampGnt   (rampGnt),
      .sendBusy  (sendBusy),
      .sendStart (sendStart),
      .sendFrame (sendFrame)
   );

   spiFrameSender u_spiFrameSender (
      .DAC_CS    (DAC_CS),
      .arstN     (arstN),
      .sendStart (sendStart),
      .sendFrame (sendFrame),
      .sendBusy  (sendBusy),
      .spiSck    (spiSck),
      .spiCsN    (spiCsN),
      .spiMosi   (spiMosi)
   );

   // Receiver model of the DAC itself
   dacFrameReceiver u_dacFrameReceiver (
      .DAC_CS  (DAC_CS),
      .arstN   (arstN),
      .dacClr  (dacClr),
      .spiSck  (spiSck),
      .spiCsN  (spiCsN),
      .spiMosi (spiMosi),
      .errClr  (errClr),
      .chanA   (chanA),
      .chanB   (chanB),
      .chanC   (chanC),
      .chanD   (chanD),
      .cmdErr  (cmdErr),
      .addrErr (addrErr)
   );

endmodule

`default_nettype wire

// ==== src/dacFrameReceiver.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dac_consts.svh"

module dacFrameReceiver import dacPkg::*; (
   input  wire         DAC_CS,
   input  wire         arstN,
   input  wire         dacClr,
   input  wire         spiSck,
   input  wire         spiCsN,
   input  wire         spiMosi,
   input  wire         errClr,
   output logic [11:0] chanA,
   output logic [11:0] chanB,
   output logic [11:0] chanC,
   output logic [11:0] chanD,
   output logic        cmdErr,
   output logic        addrErr
);

   // One extra bit so long frames stay distinguishable
   localparam int CntW = $clog2(`DAC_FRAME_BITS) + 1;

   logic            sckD;
   logic            csD;
   logic            sckRise;
   logic            csFall;
   logic            csRise;
   logic [CntW-1:0] bitCnt;
   dacFrame_u       rxFrame;
   logic            frameDone;
   logic            cmdOk;
   logic            addrOk;
   logic            doWrite;
   logic            doUpdate;
   logic [3:0]      chanSel;
   logic [11:0]     inReg [4];
   logic [11:0]     outReg [4];

   // Bus edge detection
   always_ff @(posedge DAC_CS or negedge arstN) begin
      if (!arstN) begin
         sckD <= 1'b0;
         csD  <= 1'b1;
      end else begin
         sckD <= spiSck;
         csD  <= spiCsN;
      end
   end

   assign sckRise = spiSck && !sckD;
   assign csFall  = !spiCsN && csD;
   assign csRise  = spiCsN && !csD;

   // Bit counter saturates instead of wrapping
   always_ff @(posedge DAC_CS or negedge arstN) begin
      if (!arstN) begin
         bitCnt <= '0;
      end else if (!dacClr || csFall) begin
         bitCnt <= '0;
      end else if (sckRise && !spiCsN && bitCnt != '1) begin
         bitCnt <= bitCnt + 1'b1;
      end
   end

   // Shift in MOSI on each clock rise
   always_ff @(posedge DAC_CS) begin
      if (!dacClr || csFall) begin
         rxFrame.raw <= '0;
      end else if (sckRise && !spiCsN) begin
         rxFrame.raw <= {rxFrame.raw[`DAC_FRAME_BITS-2:0], spiMosi};
      end
   end

   // Only a full 32-bit frame is ever applied
   assign frameDone = csRise && dacClr && (bitCnt == CntW'(`DAC_FRAME_BITS));

   // Command and address decode
   always_comb begin
      doWrite  = 1'b0;
      doUpdate = 1'b0;
      cmdOk    = 1'b1;
      case (rxFrame.f.cmd)
         `CMD_WRITE:  doWrite = 1'b1;
         `CMD_UPDATE: doUpdate = 1'b1;
         `CMD_WRITE_UPDATE: begin
            doWrite  = 1'b1;
            doUpdate = 1'b1;
         end
         // Power-down and the rest land here
         default: cmdOk = 1'b0;
      endcase
      addrOk  = 1'b1;
      chanSel = 4'b0000;
      case (rxFrame.f.addr)
         `ADDR_A:   chanSel = 4'b0001;
         `ADDR_B:   chanSel = 4'b0010;
         `ADDR_C:   chanSel = 4'b0100;
         `ADDR_D:   chanSel = 4'b1000;
         `ADDR_ALL: chanSel = 4'b1111;
         default:   addrOk = 1'b0;
      endcase
   end

   // Input and output channel registers
   always_ff @(posedge DAC_CS or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 4; i++) begin
            inReg[i]  <= '0;
            outReg[i] <= '0;
         end
      end else if (!dacClr) begin
         for (int i = 0; i < 4; i++) begin
            inReg[i]  <= '0;
            outReg[i] <= '0;
         end
      end else if (frameDone && cmdOk && addrOk) begin
         for (int i = 0; i < 4; i++) begin
            if (chanSel[i]) begin
               if (doWrite) begin
                  inReg[i] <= rxFrame.f.data;
               end
               // Write-and-update bypasses the old input value
               if (doUpdate) begin
                  outReg[i] <= doWrite ? rxFrame.f.data : inReg[i];
               end
            end
         end
      end
   end

   // Sticky error flags, a new error wins over errClr
   always_ff @(posedge DAC_CS or negedge arstN) begin
      if (!arstN) begin
         cmdErr  <= 1'b0;
         addrErr <= 1'b0;
      end else begin
         if (errClr) begin
            cmdErr  <= 1'b0;
            addrErr <= 1'b0;
         end
         if (frameDone && !cmdOk) begin
            cmdErr <= 1'b1;
         end
         if (frameDone && !addrOk) begin
            addrErr <= 1'b1;
         end
      end
   end

   assign chanA = outReg[0];
   assign chanB = outReg[1];
   assign chanC = outReg[2];
   assign chanD = outReg[3];

endmodule

`default_nettype wire

// ==== src/spiFrameSender.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dac_consts.svh"

module spiFrameSender import dacPkg::*; (
   input  wire        DAC_CS,
   input  wire        arstN,
   input  wire        sendStart,
   input  dacFrame_u  sendFrame,
   output logic       sendBusy,
   output logic       spiSck,
   output logic       spiCsN,
   output logic       spiMosi
);

   localparam int BitW = $clog2(`DAC_FRAME_BITS);

   logic [`DAC_FRAME_BITS-1:0] shiftReg;
   logic [BitW-1:0]            bitCnt;
   logic                       lastBit;

   assign lastBit = (bitCnt == BitW'(`DAC_FRAME_BITS - 1));

   // Busy exactly while select is low
   assign sendBusy = !spiCsN;

   // Data line parked low outside a frame
   assign spiMosi = !spiCsN && shiftReg[`DAC_FRAME_BITS-1];

   // Data path, MSB first
   always_ff @(posedge DAC_CS) begin
      if (sendStart && spiCsN) begin
         shiftReg <= sendFrame.raw;
      end else if (!spiCsN && spiSck && !lastBit) begin
         // Next bit appears while clock goes low
         shiftReg <= {shiftReg[`DAC_FRAME_BITS-2:0], 1'b0};
      end
   end

   // Select, clock and bit count
   always_ff @(posedge DAC_CS or negedge arstN) begin
      if (!arstN) begin
         spiCsN <= 1'b1;
         spiSck <= 1'b0;
         bitCnt <= '0;
      end else if (spiCsN) begin
         spiSck <= 1'b0;
         if (sendStart) begin
            spiCsN <= 1'b0;
            bitCnt <= '0;
         end
      end else if (!spiSck) begin
         // Low half of the bit
         spiSck <= 1'b1;
      end else begin
         spiSck <= 1'b0;
         if (lastBit) begin
            // Frame complete, release the bus
            spiCsN <= 1'b1;
         end else begin
            bitCnt <= bitCnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/spiArbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module spiArbiter import dacPkg::*; (
   input  wire         DAC_CS,
   input  wire         arstN,
   input  wire         dacReady,
   input  wire         hostWr,
   input  wire  [3:0]  hostCmd,
   input  wire  [3:0]  hostAddr,
   input  wire  [11:0] hostData,
   output logic        hostBusy,
   input  wire         rampReq,
   input  dacFrame_u   rampFrame,
   output logic        rampGnt,
   input  wire         sendBusy,
   output logic        sendStart,
   output dacFrame_u   sendFrame
);

   dacFrame_u hostFrame;
   // Host frame already handed to the sender
   logic      hostInFlight;
   // Round-robin state, set when the host won last
   logic      lastHost;
   logic      sendBusyD;
   logic      hostReq;
   logic      canGrant;
   logic      pickHost;
   logic      pickRamp;

   assign hostReq  = hostBusy && !hostInFlight;
   // sendStart guards the cycle before sendBusy rises
   assign canGrant = dacReady && !sendBusy && !sendStart;
   assign pickHost = canGrant && hostReq && (!rampReq || !lastHost);
   assign pickRamp = canGrant && rampReq && (!hostReq || lastHost);

   // Capture host request, strobes while busy are dropped
   always_ff @(posedge DAC_CS) begin
      if (hostWr && !hostBusy) begin
         hostFrame.f.padHi <= '0;
         hostFrame.f.cmd   <= hostCmd;
         hostFrame.f.addr  <= hostAddr;
         hostFrame.f.data  <= hostData;
         hostFrame.f.padLo <= '0;
      end
   end

   // Frame towards the sender
   always_ff @(posedge DAC_CS) begin
      if (pickHost) begin
         sendFrame <= hostFrame;
      end else if (pickRamp) begin
         sendFrame <= rampFrame;
      end
   end

   always_ff @(posedge DAC_CS or negedge arstN) begin
      if (!arstN) begin
         hostBusy     <= 1'b0;
         hostInFlight <= 1'b0;
         lastHost     <= 1'b0;
         sendBusyD    <= 1'b0;
         sendStart    <= 1'b0;
         rampGnt      <= 1'b0;
      end else begin
         sendBusyD <= sendBusy;
         sendStart <= pickHost || pickRamp;
         rampGnt   <= pickRamp;
         if (pickHost || pickRamp) begin
            lastHost <= pickHost;
         end
         if (hostWr && !hostBusy) begin
            hostBusy <= 1'b1;
         end
         if (pickHost) begin
            hostInFlight <= 1'b1;
         end else if (hostInFlight && sendBusyD && !sendBusy) begin
            // Host frame has left the sender
            hostInFlight <= 1'b0;
            hostBusy     <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/rampGenerator.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dac_consts.svh"

module rampGenerator import dacPkg::*; (
   input  wire        DAC_CS,
   input  wire        arstN,
   input  wire        rampEn,
   input  wire  [3:0] rampAddr,
   input  wire        rampGnt,
   output logic       rampReq,
   output dacFrame_u  rampFrame
);

   localparam int PerW = $clog2(`RAMP_PERIOD);

   logic [PerW-1:0] periodCnt;
   // Last value that went out on the bus
   logic [11:0]     rampValue;
   logic            periodEnd;

   assign periodEnd = (periodCnt == PerW'(`RAMP_PERIOD - 1));

   // Free-running period counter, idle while disabled
   always_ff @(posedge DAC_CS or negedge arstN) begin
      if (!arstN) begin
         periodCnt <= '0;
      end else if (!rampEn || periodEnd) begin
         periodCnt <= '0;
      end else begin
         periodCnt <= periodCnt + 1'b1;
      end
   end

   // Request level held until granted
   // A new period wins over a grant in the same cycle
   always_ff @(posedge DAC_CS or negedge arstN) begin
      if (!arstN) begin
         rampReq   <= 1'b0;
         rampValue <= '0;
      end else begin
         if (rampGnt) begin
            rampValue <= rampValue + `RAMP_STEP;
         end
         if (rampEn && periodEnd) begin
            rampReq <= 1'b1;
         end else if (rampGnt) begin
            rampReq <= 1'b0;
         end
      end
   end

   // Frame always carries the next ramp step
   always_comb begin
      rampFrame        = '0;
      rampFrame.f.cmd  = `CMD_WRITE_UPDATE;
      rampFrame.f.addr = rampAddr;
      rampFrame.f.data = rampValue + `RAMP_STEP;
   end

endmodule

`default_nettype wire

// ==== src/clearSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dac_consts.svh"

module clearSequencer (
   input  wire  DAC_CS,
   input  wire  arstN,
   output logic dacClr,
   output logic dacReady
);

   localparam int CntW = $clog2(`DAC_CLR_CYCLES);

   logic [CntW-1:0] clrCnt;

   // Hold the DAC in clear until the count expires
   always_ff @(posedge DAC_CS or negedge arstN) begin
      if (!arstN) begin
         clrCnt   <= '0;
         dacClr   <= 1'b0;
         dacReady <= 1'b0;
      end else if (!dacReady) begin
         if (clrCnt == CntW'(`DAC_CLR_CYCLES - 1)) begin
            // Release clear, bus may now be used
            dacClr   <= 1'b1;
            dacReady <= 1'b1;
         end else begin
            clrCnt <= clrCnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/dacPkg.sv ====
`default_nettype none

package dacPkg;

   `include "dac_consts.svh"

   // Field view of one DAC frame, MSB first on the wire
   typedef struct packed {
      // Leading don't-care byte
      logic [7:0]  padHi;
      logic [3:0]  cmd;
      logic [3:0]  addr;
      logic [11:0] data;
      // Trailing don't-care nibble
      logic [3:0]  padLo;
   } dacFields_s;

   // Same 32 bits seen as shift word or as decoded fields
   typedef union packed {
      logic [`DAC_FRAME_BITS-1:0] raw;
      dacFields_s                 f;
   } dacFrame_u;

endpackage

`default_nettype wire

// ==== src/dac_consts.svh ====
`ifndef DAC_CONSTS_SVH
`define DAC_CONSTS_SVH

// Serial frame length in bits
`define DAC_FRAME_BITS 32

// Cycles the DAC clear line stays low after reset
`define DAC_CLR_CYCLES 40

// Ramp generator request period in clock cycles
`define RAMP_PERIOD 200

// Ramp increment per granted frame, wraps at 12 bits
`define RAMP_STEP 12'd64

// Accepted DAC commands
// Load input register only
`define CMD_WRITE 4'b0000
// Copy input register to output
`define CMD_UPDATE 4'b0001
// Load input and output at once
`define CMD_WRITE_UPDATE 4'b0011

// Channel addresses
`define ADDR_A 4'b0000
`define ADDR_B 4'b0001
`define ADDR_C 4'b0010
`define ADDR_D 4'b0011

// Broadcast to all four channels
`define ADDR_ALL 4'b1111

`endif
